// ==== hw/booth_multiples.sv ====
// builds the shared multiples of a's mantissa used by every lane's Booth selector
`timescale 1ns/1ns

module booth_multiples (
    input  logic [fma_pkg::MAN_W-1:0] man_a,
    output logic [fma_pkg::MULT3_W-1:0] mul1,
    output logic [fma_pkg::MULT3_W-1:0] mul2,
    output logic [fma_pkg::MULT3_W-1:0] mul3,
    output logic [fma_pkg::MULT3_W-1:0] mul4,
    output logic [fma_pkg::MULT3_W-1:0] neg1,
    output logic [fma_pkg::MULT3_W-1:0] neg2,
    output logic [fma_pkg::MULT3_W-1:0] neg3,
    output logic [fma_pkg::MULT3_W-1:0] neg4
);

    assign mul1 = {{(fma_pkg::MULT3_W - fma_pkg::MAN_W){1'b0}}, man_a};
    assign mul2 = {{(fma_pkg::MULT3_W - fma_pkg::MAN_W - 1){1'b0}}, man_a, 1'b0};
    assign mul4 = {{(fma_pkg::MULT3_W - fma_pkg::MAN_W - 2){1'b0}}, man_a, 2'b00};
    assign mul3 = mul1 + mul2;  // the hard multiple

    // one's complement only, the +1 rides into the next partial-product row
    assign neg1 = ~mul1;
    assign neg2 = ~mul2;
    assign neg3 = ~mul3;
    assign neg4 = ~mul4;

endmodule

// ==== hw/booth_row_select.sv ====
// radix-8 Booth recode of one lane's b mantissa into four shifted partial-product rows
`timescale 1ns/1ns

module booth_row_select (
    input  logic [fma_pkg::MAN_W-1:0] man_b,
    input  logic [fma_pkg::MULT3_W-1:0] mul1,
    input  logic [fma_pkg::MULT3_W-1:0] mul2,
    input  logic [fma_pkg::MULT3_W-1:0] mul3,
    input  logic [fma_pkg::MULT3_W-1:0] mul4,
    input  logic [fma_pkg::MULT3_W-1:0] neg1,
    input  logic [fma_pkg::MULT3_W-1:0] neg2,
    input  logic [fma_pkg::MULT3_W-1:0] neg3,
    input  logic [fma_pkg::MULT3_W-1:0] neg4,
    output logic [fma_pkg::NUM_MUL_ROWS-1:0][fma_pkg::MUL_ROW_W-1:0] mul_rows
);

    logic [fma_pkg::MAN_W+1:0] b_ext;  // implied 0 below lsb and above msb
    fma_pkg::booth_digit_e digit [fma_pkg::NUM_MUL_ROWS];
    logic [fma_pkg::MULT3_W-1:0] pick [fma_pkg::NUM_MUL_ROWS];
    logic [fma_pkg::NUM_MUL_ROWS-1:0] row_neg;

    // window is {b[3i+2], b[3i+1], b[3i], b[3i-1]}
    function automatic fma_pkg::booth_digit_e booth_decode(input logic [3:0] win);
        case (win)
            4'b0001, 4'b0010: return fma_pkg::DIG_P1;
            4'b0011, 4'b0100: return fma_pkg::DIG_P2;
            4'b0101, 4'b0110: return fma_pkg::DIG_P3;
            4'b0111:          return fma_pkg::DIG_P4;
            4'b1000:          return fma_pkg::DIG_M4;
            4'b1001, 4'b1010: return fma_pkg::DIG_M3;
            4'b1011, 4'b1100: return fma_pkg::DIG_M2;
            4'b1101, 4'b1110: return fma_pkg::DIG_M1;
            default:          return fma_pkg::DIG_ZERO;  // 0000 and 1111
        endcase
    endfunction

    assign b_ext = {1'b0, man_b, 1'b0};

    always_comb begin
        for (int i = 0; i < fma_pkg::NUM_MUL_ROWS; i++) begin
            digit[i] = booth_decode(b_ext[fma_pkg::BOOTH_BITS*i +: fma_pkg::BOOTH_BITS+1]);
            row_neg[i] = digit[i] inside {fma_pkg::DIG_M1, fma_pkg::DIG_M2,
                                          fma_pkg::DIG_M3, fma_pkg::DIG_M4};
            case (digit[i])
                fma_pkg::DIG_P1: pick[i] = mul1;
                fma_pkg::DIG_P2: pick[i] = mul2;
                fma_pkg::DIG_P3: pick[i] = mul3;
                fma_pkg::DIG_P4: pick[i] = mul4;
                fma_pkg::DIG_M1: pick[i] = neg1;
                fma_pkg::DIG_M2: pick[i] = neg2;
                fma_pkg::DIG_M3: pick[i] = neg3;
                fma_pkg::DIG_M4: pick[i] = neg4;
                default:         pick[i] = '0;
            endcase
            // sign extend, then move to the digit's weight
            mul_rows[i] = {{(fma_pkg::MUL_ROW_W - fma_pkg::MULT3_W){row_neg[i]}}, pick[i]}
                          << (fma_pkg::BOOTH_BITS * i);
        end

        // the +1 of a negative row lands in the free low bits of the row above
        for (int i = 1; i < fma_pkg::NUM_MUL_ROWS; i++) begin
            mul_rows[i][fma_pkg::BOOTH_BITS*(i-1)] = row_neg[i-1];
        end
    end

    // top window has a 0 msb, so the last row is never negative

endmodule

// ==== hw/fma_pkg.sv ====
// shared widths, FP16 type, Booth digit encoding and unpack helpers for the FMA row
package fma_pkg;

    typedef logic [15:0] fp16_t;  // sign, 5-bit biased exponent, 10-bit fraction

    localparam int NUM_LANES = 16;
    localparam int MAN_W = 11;             // fraction plus hidden bit
    localparam int FRAC_W = MAN_W - 1;
    localparam int EXP_W = 6;              // signed true exponent
    localparam int FP16_BIAS = 15;
    localparam int EXP_MIN = 1 - FP16_BIAS;  // subnormals sit at -14

    // radix-8 Booth, 3 new bits per digit
    localparam int BOOTH_BITS = 3;
    localparam int NUM_MUL_ROWS = 4;
    localparam int MUL_ROW_W = 24;
    localparam int MULT3_W = MAN_W + 3;    // room for 4x and a sign bit
    localparam int PROD_W = 2 * MAN_W;

    // aligned sum keeps the product at its lsb and c up to NO_ADD_LIMIT above it
    localparam int ALIGN_W = 35;
    localparam int TOP_EXP_OFS = ALIGN_W - 1 - 2 * FRAC_W;  // weight of the sum msb
    localparam int NO_ADD_LIMIT = 13;

    typedef enum logic [3:0] {
        DIG_ZERO,
        DIG_P1,
        DIG_P2,
        DIG_P3,
        DIG_P4,
        DIG_M1,
        DIG_M2,
        DIG_M3,
        DIG_M4
    } booth_digit_e;

    // true exponent, subnormals and zero pinned to EXP_MIN
    function automatic logic signed [EXP_W-1:0] fp16_exp(input fp16_t v);
        return (v[14:10] == 5'd0) ? EXP_W'(EXP_MIN)
                                  : EXP_W'(int'(v[14:10]) - FP16_BIAS);
    endfunction

    // mantissa with the hidden bit restored
    function automatic logic [MAN_W-1:0] fp16_man(input fp16_t v);
        return {v[14:10] != 5'd0, v[9:0]};
    endfunction

endpackage

// ==== hw/fma_row.sv ====
// top of the FP16 FMA row, shared a decode, 16 lanes and a two-stage valid/ready pipeline
`timescale 1ns/1ns

module fma_row (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  fma_pkg::fp16_t a,
    input  fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] row_b,
    input  fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] row_c,
    output logic out_valid,
    input  logic out_ready,
    output fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] row_product
);

    logic sign_a;
    logic signed [fma_pkg::EXP_W-1:0] exp_a;
    logic [fma_pkg::MAN_W-1:0] man_a;
    logic [fma_pkg::MULT3_W-1:0] mul1, mul2, mul3, mul4;
    logic [fma_pkg::MULT3_W-1:0] neg1, neg2, neg3, neg4;

    // stage 1 inputs (_d) and registers (_q)
    logic [fma_pkg::NUM_LANES-1:0][fma_pkg::NUM_MUL_ROWS-1:0][fma_pkg::MUL_ROW_W-1:0] rows_d;
    logic [fma_pkg::NUM_LANES-1:0][fma_pkg::NUM_MUL_ROWS-1:0][fma_pkg::MUL_ROW_W-1:0] rows_q;
    logic [fma_pkg::NUM_LANES-1:0] sign_ab_d, sign_ab_q;
    logic [fma_pkg::NUM_LANES-1:0] sign_c_d, sign_c_q;
    logic signed [fma_pkg::EXP_W-1:0] exp_ab_d [fma_pkg::NUM_LANES];
    logic signed [fma_pkg::EXP_W-1:0] exp_ab_q [fma_pkg::NUM_LANES];
    logic signed [fma_pkg::EXP_W:0] exp_c_minus_ab_d [fma_pkg::NUM_LANES];
    logic signed [fma_pkg::EXP_W:0] exp_c_minus_ab_q [fma_pkg::NUM_LANES];
    logic [fma_pkg::MAN_W-1:0] man_b [fma_pkg::NUM_LANES];
    logic [fma_pkg::MAN_W-1:0] man_c_d [fma_pkg::NUM_LANES];
    logic [fma_pkg::MAN_W-1:0] man_c_q [fma_pkg::NUM_LANES];

    logic [fma_pkg::ALIGN_W-1:0] sum_mag [fma_pkg::NUM_LANES];
    logic [fma_pkg::NUM_LANES-1:0] sum_neg;
    fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] prod_d;

    logic s1_valid;
    logic s2_valid;
    logic s2_open;   // stage 2 empty or draining this cycle

    // a is unpacked once for the whole row
    assign sign_a = a[15];
    assign exp_a = fma_pkg::fp16_exp(a);
    assign man_a = fma_pkg::fp16_man(a);

    booth_multiples u_multiples (
        .man_a(man_a),
        .mul1(mul1), .mul2(mul2), .mul3(mul3), .mul4(mul4),
        .neg1(neg1), .neg2(neg2), .neg3(neg3), .neg4(neg4)
    );

    for (genvar i = 0; i < fma_pkg::NUM_LANES; i++) begin : g_lane
        fp16_unpack u_unpack (
            .sign_a(sign_a), .exp_a(exp_a), .b(row_b[i]), .c(row_c[i]),
            .sign_ab(sign_ab_d[i]), .exp_ab(exp_ab_d[i]), .sign_c(sign_c_d[i]),
            .exp_c_minus_ab(exp_c_minus_ab_d[i]), .man_b(man_b[i]), .man_c(man_c_d[i])
        );

        booth_row_select u_select (
            .man_b(man_b[i]),
            .mul1(mul1), .mul2(mul2), .mul3(mul3), .mul4(mul4),
            .neg1(neg1), .neg2(neg2), .neg3(neg3), .neg4(neg4),
            .mul_rows(rows_d[i])
        );

        lane_accumulate u_accumulate (
            .mul_rows(rows_q[i]), .sign_ab(sign_ab_q[i]), .sign_c(sign_c_q[i]),
            .exp_c_minus_ab(exp_c_minus_ab_q[i]), .man_c(man_c_q[i]),
            .sum_mag(sum_mag[i]), .sum_neg(sum_neg[i])
        );

        normalize_round u_round (
            .sum_mag(sum_mag[i]), .sum_neg(sum_neg[i]), .sign_ab(sign_ab_q[i]),
            .exp_ab(exp_ab_q[i]), .exp_c_minus_ab(exp_c_minus_ab_q[i]),
            .man_c(man_c_q[i]), .product(prod_d[i])
        );
    end

    // a stage loads when empty or when its successor takes its item
    assign s2_open = !s2_valid || out_ready;
    assign in_ready = !s1_valid || s2_open;
    assign out_valid = s2_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                s1_valid <= in_valid;
            end
            if (s2_open) begin
                s2_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            rows_q <= rows_d;
            sign_ab_q <= sign_ab_d;
            sign_c_q <= sign_c_d;
            exp_ab_q <= exp_ab_d;
            exp_c_minus_ab_q <= exp_c_minus_ab_d;
            man_c_q <= man_c_d;
        end
        if (s1_valid && s2_open) begin
            row_product <= prod_d;   // held while the sink stalls
        end
    end

endmodule

// ==== hw/fp16_unpack.sv ====
// per-lane operand decode, gives product sign/exponent and the c alignment distance
`timescale 1ns/1ns

module fp16_unpack (
    input  logic sign_a,
    input  logic signed [fma_pkg::EXP_W-1:0] exp_a,    // a is decoded once for the row
    input  fma_pkg::fp16_t b,
    input  fma_pkg::fp16_t c,
    output logic sign_ab,
    output logic signed [fma_pkg::EXP_W-1:0] exp_ab,
    output logic sign_c,
    output logic signed [fma_pkg::EXP_W:0] exp_c_minus_ab,
    output logic [fma_pkg::MAN_W-1:0] man_b,
    output logic [fma_pkg::MAN_W-1:0] man_c
);

    logic sign_b;
    logic signed [fma_pkg::EXP_W-1:0] exp_b;
    logic signed [fma_pkg::EXP_W-1:0] exp_c;

    assign sign_b = b[15];
    assign sign_c = c[15];

    assign exp_b = fma_pkg::fp16_exp(b);
    assign exp_c = fma_pkg::fp16_exp(c);

    assign man_b = fma_pkg::fp16_man(b);
    assign man_c = fma_pkg::fp16_man(c);

    assign sign_ab = sign_a ^ sign_b;

    // range -28..30 fits, bias is put back after normalization
    assign exp_ab = exp_a + exp_b;

    // one extra bit, c at -14 against a product at +30 gives -44
    assign exp_c_minus_ab = exp_c - exp_ab;

endmodule

// ==== hw/lane_accumulate.sv ====
// reduces one lane's partial products and adds the aligned c mantissa, returns |sum| and sign
`timescale 1ns/1ns

module lane_accumulate (
    input  logic [fma_pkg::NUM_MUL_ROWS-1:0][fma_pkg::MUL_ROW_W-1:0] mul_rows,
    input  logic sign_ab,
    input  logic sign_c,
    input  logic signed [fma_pkg::EXP_W:0] exp_c_minus_ab,
    input  logic [fma_pkg::MAN_W-1:0] man_c,
    output logic [fma_pkg::ALIGN_W-1:0] sum_mag,
    output logic sum_neg   // result sign relative to sign_ab
);

    logic [fma_pkg::MUL_ROW_W-1:0] s1;
    logic [fma_pkg::MUL_ROW_W-1:0] maj1;
    logic [fma_pkg::MUL_ROW_W-1:0] c1;
    logic [fma_pkg::MUL_ROW_W-1:0] s2;
    logic [fma_pkg::MUL_ROW_W-1:0] maj2;
    logic [fma_pkg::MUL_ROW_W-1:0] c2;
    logic [fma_pkg::PROD_W-1:0] prod;

    logic no_add;
    logic right_shift;
    logic eff_sub;
    logic raw_neg;
    logic zero_sum;
    logic [fma_pkg::EXP_W:0] shift_amt;
    logic [fma_pkg::ALIGN_W-1:0] c_ext;
    logic [fma_pkg::ALIGN_W-1:0] c_aligned;
    logic [fma_pkg::ALIGN_W-1:0] addend;
    logic [fma_pkg::ALIGN_W-1:0] prod_ext;
    logic [fma_pkg::ALIGN_W-1:0] sum_raw;

    // first 3:2 level on rows 0..2
    assign s1 = mul_rows[0] ^ mul_rows[1] ^ mul_rows[2];
    assign maj1 = (mul_rows[0] & mul_rows[1]) | (mul_rows[1] & mul_rows[2])
                | (mul_rows[0] & mul_rows[2]);
    assign c1 = {maj1[fma_pkg::MUL_ROW_W-2:0], 1'b0};

    // second level folds in row 3
    assign s2 = s1 ^ c1 ^ mul_rows[3];
    assign maj2 = (s1 & c1) | (c1 & mul_rows[3]) | (s1 & mul_rows[3]);
    assign c2 = {maj2[fma_pkg::MUL_ROW_W-2:0], 1'b0};

    // true product is below 2^22, upper row bits only carry sign-extension junk
    assign prod = s2[fma_pkg::PROD_W-1:0] + c2[fma_pkg::PROD_W-1:0];

    // c sits with FRAC_W zeros below it so both share the product's lsb weight
    assign c_ext = {{(fma_pkg::ALIGN_W - fma_pkg::MAN_W - fma_pkg::FRAC_W){1'b0}},
                    man_c,
                    {fma_pkg::FRAC_W{1'b0}}};

    assign right_shift = exp_c_minus_ab[fma_pkg::EXP_W];
    assign shift_amt = right_shift ? -exp_c_minus_ab : exp_c_minus_ab;
    assign c_aligned = right_shift ? (c_ext >> shift_amt) : (c_ext << shift_amt);

    assign no_add = exp_c_minus_ab > fma_pkg::NO_ADD_LIMIT;  // product too small to matter

    // subtract as invert plus carry-in
    assign eff_sub = sign_c ^ sign_ab;
    assign addend = eff_sub ? ~c_aligned : c_aligned;
    assign prod_ext = {{(fma_pkg::ALIGN_W - fma_pkg::PROD_W){1'b0}}, prod};
    assign sum_raw = addend + prod_ext + {{(fma_pkg::ALIGN_W - 1){1'b0}}, eff_sub};

    assign raw_neg = sum_raw[fma_pkg::ALIGN_W-1];
    assign zero_sum = (sum_raw == '0);
    assign sum_mag = raw_neg ? -sum_raw : sum_raw;

    // bypass takes c's own sign, an exact zero is -0 only when both terms are negative
    always_comb begin
        if (no_add) begin
            sum_neg = sign_c ^ sign_ab;
        end else if (zero_sum) begin
            sum_neg = sign_ab & ~sign_c;
        end else begin
            sum_neg = raw_neg;
        end
    end

endmodule

// ==== hw/normalize_round.sv ====
// normalizes and rounds one lane's sum to FP16, or passes c through when the product is lost
`timescale 1ns/1ns

module normalize_round (
    input  logic [fma_pkg::ALIGN_W-1:0] sum_mag,
    input  logic sum_neg,
    input  logic sign_ab,
    input  logic signed [fma_pkg::EXP_W-1:0] exp_ab,
    input  logic signed [fma_pkg::EXP_W:0] exp_c_minus_ab,
    input  logic [fma_pkg::MAN_W-1:0] man_c,
    output fma_pkg::fp16_t product
);

    int lz;
    int shift_lim;
    int shift_amt;
    int res_exp;
    int biased;

    logic no_add;
    logic [fma_pkg::ALIGN_W-1:0] norm;
    logic [fma_pkg::MAN_W-1:0] man_trunc;
    logic guard_bit;
    logic round_bit;
    logic sticky_bit;
    logic round_up;
    logic [fma_pkg::MAN_W:0] man_inc;   // extra msb catches the rounding carry
    logic [fma_pkg::MAN_W-1:0] res_man;
    logic [4:0] exp_field;

    // leading-zero count, the highest set bit wins
    always_comb begin
        lz = fma_pkg::ALIGN_W;
        for (int i = 0; i < fma_pkg::ALIGN_W; i++) begin
            if (sum_mag[i]) begin
                lz = fma_pkg::ALIGN_W - 1 - i;
            end
        end
    end

    // stop shifting once the exponent reaches EXP_MIN, the rest stays subnormal
    assign shift_lim = int'(exp_ab) + fma_pkg::TOP_EXP_OFS - fma_pkg::EXP_MIN;
    assign shift_amt = (lz < shift_lim) ? lz : shift_lim;
    assign norm = sum_mag << shift_amt;

    assign man_trunc = norm[fma_pkg::ALIGN_W-1 -: fma_pkg::MAN_W];
    assign guard_bit = norm[fma_pkg::ALIGN_W-fma_pkg::MAN_W-1];
    assign round_bit = norm[fma_pkg::ALIGN_W-fma_pkg::MAN_W-2];
    assign sticky_bit = |norm[fma_pkg::ALIGN_W-fma_pkg::MAN_W-3:0];

    // nearest even, ties go up only from an odd lsb
    assign round_up = guard_bit & (round_bit | sticky_bit | man_trunc[0]);
    assign man_inc = {1'b0, man_trunc} + {{fma_pkg::MAN_W{1'b0}}, round_up};

    assign no_add = exp_c_minus_ab > fma_pkg::NO_ADD_LIMIT;

    always_comb begin
        if (no_add) begin
            res_man = man_c;   // c is returned as is
            res_exp = int'(exp_ab) + int'(exp_c_minus_ab);
        end else if (man_inc[fma_pkg::MAN_W]) begin
            res_man = {1'b1, {(fma_pkg::MAN_W - 1){1'b0}}};  // 1.111.. rounded to 10.000..
            res_exp = int'(exp_ab) + fma_pkg::TOP_EXP_OFS - shift_amt + 1;
        end else begin
            res_man = man_inc[fma_pkg::MAN_W-1:0];
            res_exp = int'(exp_ab) + fma_pkg::TOP_EXP_OFS - shift_amt;
        end
    end

    // no hidden bit means subnormal or zero, exponent field 0
    assign biased = res_exp + fma_pkg::FP16_BIAS;
    assign exp_field = res_man[fma_pkg::MAN_W-1] ? biased[4:0] : 5'd0;

    assign product = {sign_ab ^ sum_neg, exp_field, res_man[fma_pkg::FRAC_W-1:0]};

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile the FMA row testbench with Verilator, run it, and look for the fail message in the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_fma_row --Mdir obj_dir -o tb_fma_row
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_fma_row > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim/tb_fma_row.sv ====
// testbench for the FMA row, drives random FP16 rows and checks them against an integer model
`timescale 1ns/1ns

module tb_fma_row;

    localparam int ITEMS_PER_TEST = 40;
    localparam int NUM_TESTS = 6;
    localparam int TOTAL_ITEMS = ITEMS_PER_TEST * NUM_TESTS;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_ITEMS + 100;
    localparam int DRAIN_LIMIT = 200;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    fma_pkg::fp16_t a;
    fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] row_b;
    fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] row_c;
    logic out_valid;
    logic out_ready;
    fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] row_product;

    fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] exp_now;  // expected row of the driven item
    fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] exp_q [$];
    int stamp_q [$];   // cycle of the input transfer
    bit timed_q [$];   // latency is fixed only while out_ready stays high

    int seed = 85510;
    bit ready_random = 1'b0;
    bit ready_next;    // out_ready for the coming cycle
    int cycles = 0;
    int errors = 0;
    int checked = 0;

    fma_row UUT (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready), .a(a),
        .row_b(row_b), .row_c(row_c), .out_valid(out_valid), .out_ready(out_ready),
        .row_product(row_product)
    );

    always #2 clk = ~clk;

    // drawn at the edge, driven 1 ns later
    always @(posedge clk) begin
        ready_next = ready_random ? 1'($random(seed)) : 1'b1;
        #1;
        out_ready = ready_next;
    end

    function automatic int pick(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    function automatic int true_exp(input fma_pkg::fp16_t v);
        return (v[14:10] == 5'd0) ? -14 : int'(v[14:10]) - 15;
    endfunction

    // signed integer to FP16, nearest even at 11 significant bits
    function automatic fma_pkg::fp16_t int_to_fp16(input int v);
        int m;
        int p;
        int sh;
        int q;
        int rem;
        logic s;
        s = (v < 0);
        m = s ? -v : v;
        if (m == 0) begin
            return {s, 15'd0};
        end
        p = 0;
        while ((m >> (p + 1)) != 0) begin
            p++;
        end
        if (p <= 10) begin
            q = m << (10 - p);
        end else begin
            sh = p - 10;
            q = m >> sh;
            rem = m - (q << sh);
            if (rem > (1 << (sh - 1)) || (rem == (1 << (sh - 1)) && q % 2 == 1)) begin
                q++;
            end
            if (q == 2048) begin
                q = 1024;   // rounding carried into a new binade
                p++;
            end
        end
        return {s, 5'(p + 15), 10'(q)};
    endfunction

    // mode 1 products, 2 exact multiply-add, 3 bypass, 4 a random mix per lane
    task automatic make_item(input int mode);
        int ai;
        int bi;
        int ci;
        int sum;
        int kind;
        int ec_min;
        ai = (mode == 1) ? pick(1, 255) : pick(1, 45);
        if (pick(0, 1) == 1) ai = -ai;
        a = int_to_fp16(ai);
        if (mode == 3) begin
            a = (pick(0, 1) == 0) ? 16'h0000
                                  : {1'(pick(0, 1)), 5'(pick(1, 10)), 10'(pick(0, 1023))};
        end
        for (int i = 0; i < fma_pkg::NUM_LANES; i++) begin
            kind = (mode == 4) ? pick(1, 3) : mode;
            bi = (kind == 1) ? pick(1, 255) : pick(1, 45);
            if (pick(0, 1) == 1) bi = -bi;
            if (kind == 1) begin
                row_b[i] = int_to_fp16(bi);
                row_c[i] = 16'h0000;
                exp_now[i] = int_to_fp16(ai * bi);
            end else if (kind == 2) begin
                do begin
                    ci = pick(-2047, 2047);
                    sum = ai * bi + ci;
                end while (sum == 0 || sum > 2047 || sum < -2047);
                row_b[i] = int_to_fp16(bi);
                row_c[i] = int_to_fp16(ci);
                exp_now[i] = int_to_fp16(sum);
            end else begin
                row_b[i] = {1'(pick(0, 1)), 5'(pick(0, 10)), 10'(pick(0, 1023))};
                ec_min = true_exp(a) + true_exp(row_b[i]) + 14 + 15;  // c exponent at least 14 above
                row_c[i] = {1'(pick(0, 1)), 5'(pick(ec_min, 30)), 10'(pick(0, 1023))};
                exp_now[i] = row_c[i];
            end
        end
    endtask

    // inputs are stable from the falling edge to the next rising edge
    task automatic send_item(input int mode);
        make_item(mode);
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic run_test(input string name, input int mode, input bit gaps);
        int err_start;
        int left;
        err_start = errors;
        for (int n = 0; n < ITEMS_PER_TEST; n++) begin
            if (gaps && pick(0, 3) == 0) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            send_item(mode);
        end
        in_valid = 1'b0;
        left = DRAIN_LIMIT;
        while (exp_q.size() != 0 && left > 0) begin
            @(posedge clk);
            #1;
            left--;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d items of test %s never came out", exp_q.size(), name);
            exp_q.delete();
            stamp_q.delete();
            timed_q.delete();
        end
        $display("test %s: %0d items, %0d errors", name, ITEMS_PER_TEST, errors - err_start);
    endtask

    task automatic check_row();
        fma_pkg::fp16_t [fma_pkg::NUM_LANES-1:0] expv;
        int stamp;
        bit timed;
        expv = exp_q.pop_front();
        stamp = stamp_q.pop_front();
        timed = timed_q.pop_front();
        checked++;
        for (int i = 0; i < fma_pkg::NUM_LANES; i++) begin
            assert (row_product[i] === expv[i]) else begin
                errors++;
                $display("Fail at %0t ns: lane %0d got %h expected %h",
                         $time, i, row_product[i], expv[i]);
            end
        end
        if (timed) begin
            assert (cycles - stamp == 2) else begin
                errors++;
                $display("item came out %0d cycles after its input instead of 2", cycles - stamp);
            end
        end
    endtask

    // transfers are seen at the falling edge before the rising edge that takes them
    always @(negedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end else begin
            if (!rst && in_valid && in_ready) begin
                exp_q.push_back(exp_now);
                stamp_q.push_back(cycles);
                timed_q.push_back(!ready_random);
            end
            if (!rst && out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("output row at %0t ns with no item pending", $time);
                end else begin
                    check_row();
                end
            end
        end
    end

    a_hold : assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(row_product))
        else begin
            errors++;
            $display("output row changed while the sink stalled at %0t ns", $time);
        end

    a_ready : assert property (@(posedge clk) disable iff (rst)
        !in_ready |-> out_valid && !out_ready)
        else begin
            errors++;
            $display("in_ready low at %0t ns without a stalled output", $time);
        end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b1;
        a = '0;
        row_b = '0;
        row_c = '0;
        exp_now = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!out_valid && in_ready) else begin
            errors++;
            $display("stream not idle after reset");
        end
        $display("test reset: out_valid %b, in_ready %b", out_valid, in_ready);
        run_test("products", 1, 1'b0);
        run_test("multiply_add", 2, 1'b0);
        run_test("bypass", 3, 1'b0);
        run_test("mixed_lanes", 4, 1'b0);
        run_test("stream_full", 4, 1'b0);
        ready_random = 1'b1;
        run_test("stream_stall", 4, 1'b1);
        ready_random = 1'b0;
        $display("%0d tests, %0d rows checked, %0d errors", NUM_TESTS, checked, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/fma_pkg.sv
hw/fp16_unpack.sv
hw/booth_multiples.sv
hw/booth_row_select.sv
hw/lane_accumulate.sv
hw/normalize_round.sv
hw/fma_row.sv
sim/tb_fma_row.sv
